// File: Bender.yml
package:
  name: dual_clock_merge

sources:
  # RTL, packages first
  - files:
      - hdl/cdc_pkg.sv
      - hdl/stream_pkg.sv
      - hdl/cdc_fifo.sv
      - hdl/stream_merger.sv
      - hdl/dual_clock_merge.sv

  # Testbench and bound assertions
  - target: test
    files:
      - test/dual_clock_merge_properties.sv
      - test/dual_clock_merge_tb.sv

// File: dual_clock_merge.f
hdl/cdc_pkg.sv
hdl/stream_pkg.sv
hdl/cdc_fifo.sv
hdl/stream_merger.sv
hdl/dual_clock_merge.sv
test/dual_clock_merge_properties.sv
test/dual_clock_merge_tb.sv

// File: hdl/cdc_fifo.sv
`timescale 1ns/1ps
//////////////////////////////
// Dual-clock FIFO
// Written on in_clk_i, read on out_clk_i
// Gray pointers cross through flop synchronizers
//////////////////////////////
module cdc_fifo #(
  parameter type elem_t = logic [7:0]  // Payload held in each entry
) (
  input  logic  in_clk_i,     // Source domain clock
  input  logic  out_clk_i,    // Destination domain clock
  input  logic  rst_i,        // Sync reset, sampled in both domains

  input  logic  in_valid_i,   // Source element valid
  input  elem_t in_data_i,    // Source element
  output logic  in_ready_o,   // Space available

  output logic  out_valid_o,  // Head element valid
  output elem_t out_data_o,   // Head element
  input  logic  out_ready_i   // Head consumed
);

  import cdc_pkg::*;

  //////////////////////////////
  // Signals
  //////////////////////////////

  // Storage, written only in the source domain
  elem_t mem [FIFO_DEPTH];

  // Write side
  ptr_t wr_bin_q;                   // Binary write pointer
  ptr_t wr_bin_nxt;                 // Write pointer plus one
  ptr_t wr_gray_q;                  // Gray write pointer, launched to read side
  ptr_t rd_gray_sync [SYNC_STAGES]; // Read pointer synchronizer chain
  ptr_t rd_bin_in;                  // Read pointer seen from write side
  logic in_hs;                      // Write handshake

  // Read side
  ptr_t rd_bin_q;                   // Binary read pointer
  ptr_t rd_bin_nxt;                 // Read pointer plus one
  ptr_t rd_gray_q;                  // Gray read pointer, launched to write side
  ptr_t wr_gray_sync [SYNC_STAGES]; // Write pointer synchronizer chain
  ptr_t wr_bin_out;                 // Write pointer seen from read side
  logic out_hs;                     // Read handshake

  //////////////////////////////
  // Write domain
  //////////////////////////////

  assign in_hs      = in_valid_i & in_ready_o;
  assign wr_bin_nxt = wr_bin_q + 1'b1;
  assign rd_bin_in  = gray_to_bin(rd_gray_sync[SYNC_STAGES-1]);

  // Full when indexes match but wrap bits differ
  // Stale read pointer only makes this pessimistic
  assign in_ready_o = !((wr_bin_q[FIFO_ADDR_W] != rd_bin_in[FIFO_ADDR_W]) &&
                        (wr_bin_q[FIFO_ADDR_W-1:0] == rd_bin_in[FIFO_ADDR_W-1:0]));

  always_ff @(posedge in_clk_i) begin
    if (rst_i) begin
      wr_bin_q  <= '0;
      wr_gray_q <= '0;
    end else if (in_hs) begin
      wr_bin_q  <= wr_bin_nxt;
      wr_gray_q <= bin_to_gray(wr_bin_nxt);  // Glitch free copy for crossing
    end
  end

  // Bring read pointer into the write domain
  always_ff @(posedge in_clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= '0;
      end
    end else begin
      rd_gray_sync[0] <= rd_gray_q;  // First flop may go metastable
      for (int i = 1; i < SYNC_STAGES; i++) begin
        rd_gray_sync[i] <= rd_gray_sync[i-1];
      end
    end
  end

  always_ff @(posedge in_clk_i) begin
    if (in_hs) begin
      mem[wr_bin_q[FIFO_ADDR_W-1:0]] <= in_data_i;
    end
  end

  //////////////////////////////
  // Read domain
  //////////////////////////////

  assign out_hs      = out_valid_o & out_ready_i;
  assign rd_bin_nxt  = rd_bin_q + 1'b1;
  assign wr_bin_out  = gray_to_bin(wr_gray_sync[SYNC_STAGES-1]);
  assign out_valid_o = (rd_bin_q != wr_bin_out);       // Not empty
  assign out_data_o  = mem[rd_bin_q[FIFO_ADDR_W-1:0]]; // Head read straight from storage

  always_ff @(posedge out_clk_i) begin
    if (rst_i) begin
      rd_bin_q  <= '0;
      rd_gray_q <= '0;
    end else if (out_hs) begin
      rd_bin_q  <= rd_bin_nxt;
      rd_gray_q <= bin_to_gray(rd_bin_nxt);
    end
  end

  // Bring write pointer into the read domain
  always_ff @(posedge out_clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= '0;
      end
    end else begin
      wr_gray_sync[0] <= wr_gray_q;
      for (int i = 1; i < SYNC_STAGES; i++) begin
        wr_gray_sync[i] <= wr_gray_sync[i-1];
      end
    end
  end

endmodule

// File: hdl/cdc_pkg.sv
//////////////////////////////
// Clock crossing package
// FIFO sizing, synchronizer depth and gray code helpers
//////////////////////////////
package cdc_pkg;

  localparam int FIFO_ADDR_W = 2;                 // log2 of FIFO depth
  localparam int FIFO_DEPTH  = 1 << FIFO_ADDR_W;  // Entries per FIFO
  localparam int SYNC_STAGES = 2;                 // Flops per pointer synchronizer

  // Pointer with one extra wrap bit above the index
  typedef logic [FIFO_ADDR_W:0] ptr_t;

  // Binary to gray, one bit changes per increment
  function automatic ptr_t bin_to_gray(input ptr_t bin);
    return bin ^ (bin >> 1);
  endfunction

  // Gray back to binary, running xor from the top bit down
  function automatic ptr_t gray_to_bin(input ptr_t gray);
    ptr_t bin;
    bin[FIFO_ADDR_W] = gray[FIFO_ADDR_W];
    for (int i = FIFO_ADDR_W - 1; i >= 0; i--) begin
      bin[i] = bin[i+1] ^ gray[i];
    end
    return bin;
  endfunction

endpackage

// File: hdl/dual_clock_merge.sv
`timescale 1ns/1ps
//////////////////////////////
// Dual clock stream merge
// Sample and command streams cross into the
// output domain and merge into one tagged stream
//////////////////////////////
module dual_clock_merge (
  input  logic                    samp_clk_i,   // Sample domain clock
  input  logic                    cmd_clk_i,    // Command domain clock
  input  logic                    out_clk_i,    // Output domain clock
  input  logic                    rst_i,        // Sync reset, held across all domains

  // Sample input, samp_clk_i domain
  input  logic                    samp_valid_i,
  input  stream_pkg::sample_t     samp_data_i,
  output logic                    samp_ready_o,

  // Command input, cmd_clk_i domain
  input  logic                    cmd_valid_i,
  input  stream_pkg::cmd_t        cmd_data_i,
  output logic                    cmd_ready_o,

  // Merged output, out_clk_i domain
  output logic                    out_valid_o,
  output stream_pkg::stream_src_e out_src_o,
  output stream_pkg::word_t       out_data_o,
  input  logic                    out_ready_i
);

  import stream_pkg::*;

  //////////////////////////////
  // FIFO heads in out_clk_i domain
  //////////////////////////////

  logic    samp_head_valid;  // Sample FIFO not empty
  sample_t samp_head_data;   // Oldest sample
  logic    samp_head_ready;  // Merger takes sample
  logic    cmd_head_valid;   // Command FIFO not empty
  cmd_t    cmd_head_data;    // Oldest command
  logic    cmd_head_ready;   // Merger takes command

  cdc_fifo #(
    .elem_t(sample_t)
  ) u_samp_fifo (
    .in_clk_i   (samp_clk_i),
    .out_clk_i  (out_clk_i),
    .rst_i      (rst_i),
    .in_valid_i (samp_valid_i),
    .in_data_i  (samp_data_i),
    .in_ready_o (samp_ready_o),
    .out_valid_o(samp_head_valid),
    .out_data_o (samp_head_data),
    .out_ready_i(samp_head_ready)
  );

  cdc_fifo #(
    .elem_t(cmd_t)
  ) u_cmd_fifo (
    .in_clk_i   (cmd_clk_i),
    .out_clk_i  (out_clk_i),
    .rst_i      (rst_i),
    .in_valid_i (cmd_valid_i),
    .in_data_i  (cmd_data_i),
    .in_ready_o (cmd_ready_o),
    .out_valid_o(cmd_head_valid),
    .out_data_o (cmd_head_data),
    .out_ready_i(cmd_head_ready)
  );

  // Round-robin merge onto the output port
  stream_merger u_merger (
    .out_clk_i   (out_clk_i),
    .rst_i       (rst_i),
    .samp_valid_i(samp_head_valid),
    .samp_data_i (samp_head_data),
    .samp_ready_o(samp_head_ready),
    .cmd_valid_i (cmd_head_valid),
    .cmd_data_i  (cmd_head_data),
    .cmd_ready_o (cmd_head_ready),
    .out_valid_o (out_valid_o),
    .out_src_o   (out_src_o),
    .out_data_o  (out_data_o),
    .out_ready_i (out_ready_i)
  );

endmodule

// File: hdl/stream_merger.sv
`timescale 1ns/1ps
//////////////////////////////
// Stream merger
// Round-robin pick of two FIFO heads into
// one registered, source tagged output word
//////////////////////////////
module stream_merger (
  input  logic                    out_clk_i,    // Output domain clock
  input  logic                    rst_i,        // Sync reset

  input  logic                    samp_valid_i, // Sample head valid
  input  stream_pkg::sample_t     samp_data_i,  // Sample head data
  output logic                    samp_ready_o, // Sample head taken

  input  logic                    cmd_valid_i,  // Command head valid
  input  stream_pkg::cmd_t        cmd_data_i,   // Command head data
  output logic                    cmd_ready_o,  // Command head taken

  output logic                    out_valid_o,  // Output word valid
  output stream_pkg::stream_src_e out_src_o,    // Source of output word
  output stream_pkg::word_t       out_data_o,   // Output word
  input  logic                    out_ready_i   // Downstream accepts
);

  import stream_pkg::*;

  logic        load_en;    // Output register empty or draining
  logic        pick_cmd;   // Command head wins this cycle
  logic        take;       // A head moves into the register
  stream_src_e last_src_q; // Source served most recently

  //////////////////////////////
  // Arbitration
  //////////////////////////////

  assign load_en = !out_valid_o || out_ready_i;

  // Command wins alone, or on a tie when sample went last
  assign pick_cmd = cmd_valid_i && (!samp_valid_i || (last_src_q == SRC_SAMPLE));

  assign cmd_ready_o  = load_en && pick_cmd;
  assign samp_ready_o = load_en && samp_valid_i && !pick_cmd;
  assign take         = cmd_ready_o || samp_ready_o;

  always_ff @(posedge out_clk_i) begin
    if (rst_i) begin
      last_src_q <= SRC_SAMPLE;  // So command wins first tie
    end else if (take) begin
      last_src_q <= pick_cmd ? SRC_CMD : SRC_SAMPLE;
    end
  end

  //////////////////////////////
  // Output register
  //////////////////////////////

  always_ff @(posedge out_clk_i) begin
    if (rst_i) begin
      out_valid_o <= 1'b0;
    end else if (load_en) begin
      out_valid_o <= take;  // Refill or go empty
    end
  end

  // Payload and tag, loaded only on a take
  always_ff @(posedge out_clk_i) begin
    if (take) begin
      out_src_o  <= pick_cmd ? SRC_CMD : SRC_SAMPLE;
      out_data_o <= pick_cmd ? word_t'(cmd_data_i) : word_t'(samp_data_i); // Zero-extend
    end
  end

endmodule

// File: hdl/stream_pkg.sv
//////////////////////////////
// Stream payload package
// Sample and command payloads, source tag, merged word
//////////////////////////////
package stream_pkg;

  localparam int SAMPLE_W = 8;   // Sample payload width
  localparam int CMD_W    = 16;  // Command payload width
  localparam int WORD_W   = 16;  // Merged output width

  // Payload of the sample stream
  typedef logic [SAMPLE_W-1:0] sample_t;

  // Payload of the command stream
  typedef logic [CMD_W-1:0] cmd_t;

  // Merged data word, samples are zero-extended into it
  typedef logic [WORD_W-1:0] word_t;

  // Source tag carried next to each merged word
  typedef enum logic {
    SRC_SAMPLE = 1'b0,  // Word came from the sample FIFO
    SRC_CMD    = 1'b1   // Word came from the command FIFO
  } stream_src_e;

endpackage

// File: test/dual_clock_merge_properties.sv
`timescale 1ns/1ps
//////////////////////////////
// Stream merger properties
// Reset, output hold and single take
//////////////////////////////
module dual_clock_merge_properties (
  input logic                    out_clk_i,
  input logic                    rst_i,
  input logic                    samp_ready_o,  // Sample head taken
  input logic                    cmd_ready_o,   // Command head taken
  input logic                    out_valid_o,
  input stream_pkg::stream_src_e out_src_o,
  input stream_pkg::word_t       out_data_o,
  input logic                    out_ready_i
);

  // Output register comes up empty
  a_reset_empty: assert property (@(posedge out_clk_i) rst_i |=> !out_valid_o)
    else $error("out_valid_o high in the cycle after reset");

  // Stalled word holds until accepted
  a_hold_stall: assert property (@(posedge out_clk_i) disable iff (rst_i)
    (out_valid_o && !out_ready_i) |=>
      (out_valid_o && $stable(out_data_o) && $stable(out_src_o)))
    else $error("output word changed while stalled");

  // At most one head per cycle
  a_one_take: assert property (@(posedge out_clk_i) !(samp_ready_o && cmd_ready_o))
    else $error("both FIFO heads taken in one cycle");

endmodule

bind stream_merger dual_clock_merge_properties u_merger_props (
  .out_clk_i   (out_clk_i),
  .rst_i       (rst_i),
  .samp_ready_o(samp_ready_o),
  .cmd_ready_o (cmd_ready_o),
  .out_valid_o (out_valid_o),
  .out_src_o   (out_src_o),
  .out_data_o  (out_data_o),
  .out_ready_i (out_ready_i)
);

// File: test/dual_clock_merge_tb.sv
`timescale 1ns/1ps
//////////////////////////////
// Dual clock merge testbench
// Directed tests on three clocks with
// per-source scoreboards and fairness check
//////////////////////////////
module dual_clock_merge_tb;

  import cdc_pkg::*;
  import stream_pkg::*;

  localparam int          TIMEOUT_CYCLES = 32 * (SYNC_STAGES + 2); // Per wait loop
  localparam int          STALL_CYCLES   = 8 * (SYNC_STAGES + 2);  // Idle span meaning full
  localparam logic [31:0] SEED           = 32'd6;

  logic        samp_clk_i = 1'b0;
  logic        cmd_clk_i  = 1'b0;
  logic        out_clk_i  = 1'b0;
  logic        rst_i;
  logic        samp_valid_i;
  sample_t     samp_data_i;
  logic        samp_ready_o;
  logic        cmd_valid_i;
  cmd_t        cmd_data_i;
  logic        cmd_ready_o;
  logic        out_valid_o;
  stream_src_e out_src_o;
  word_t       out_data_o;
  logic        out_ready_i;

  word_t       exp_samp [$];            // Samples still expected at the output
  word_t       exp_cmd [$];             // Commands still expected at the output
  word_t       mon_exp;                 // Word popped by the output monitor
  int          rx_samp, rx_cmd;         // Words seen per source
  int          n_checks, n_errors, n_tests;
  int          test_err_start;
  string       cur_test = "init";
  logic [31:0] rng_state = SEED;
  logic        pattern_on = 1'b0;       // Random out_ready_i running
  logic        rr_check_en = 1'b0;      // Fairness check armed
  logic        rr_seen_samp, rr_seen_cmd;
  logic        samp_take, cmd_take, both_heads;
  stream_src_e last_taken;              // Source the merger served last

  always #3 samp_clk_i = ~samp_clk_i;  // 6 ns
  always #5 cmd_clk_i  = ~cmd_clk_i;   // 10 ns
  always #2 out_clk_i  = ~out_clk_i;   // 4 ns

  dual_clock_merge u_dual_clock_merge (.*);

  //////////////////////////////
  // Helpers
  //////////////////////////////

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  task automatic report_error(input string what);
    n_errors++;
    $display("ERROR: test %s, %s", cur_test, what);
  endtask

  task automatic print_summary();
    $display("summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
  endtask

  // Timeout exit, nothing runs after it
  task automatic abort_run(input string what);
    report_error(what);
    print_summary();
    $display("sim failed");
    $finish;
  endtask

  task automatic check_word(input string name, input word_t exp, input word_t act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("MISMATCH %s/%s: expected %h, actual %h", cur_test, name, exp, act);
    end
  endtask

  task automatic check_src(input string name, input stream_src_e exp, input stream_src_e act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("MISMATCH %s/%s: expected %s, actual %s", cur_test, name, exp.name(), act.name());
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    n_checks++;
    if (exp != act) begin
      n_errors++;
      $display("MISMATCH %s/%s: expected %0d, actual %0d", cur_test, name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    n_checks++;
    if (exp !== act) begin
      n_errors++;
      $display("MISMATCH %s/%s: expected %b, actual %b", cur_test, name, exp, act);
    end
  endtask

  task automatic start_test(input string name);
    cur_test       = name;
    test_err_start = n_errors;
  endtask

  task automatic finish_test();
    n_tests++;
    $display("test %-14s %s (%0d errors)", cur_test,
             (n_errors == test_err_start) ? "ok" : "FAILED", n_errors - test_err_start);
  endtask

  //////////////////////////////
  // Monitors
  //////////////////////////////

  // Output side, pops the scoreboard of the tagged source
  always @(posedge out_clk_i) begin
    if (!rst_i && out_valid_o && out_ready_i) begin
      if (out_src_o == SRC_SAMPLE) begin
        if (exp_samp.size() == 0) begin
          report_error("sample word arrived with none expected");
        end else begin
          mon_exp = exp_samp.pop_front();
          check_word("sample data", mon_exp, out_data_o);
        end
        rx_samp++;
      end else begin
        if (exp_cmd.size() == 0) begin
          report_error("command word arrived with none expected");
        end else begin
          mon_exp = exp_cmd.pop_front();
          check_word("command data", mon_exp, out_data_o);
        end
        rx_cmd++;
      end
    end
  end

  // Head takes inside the top, tie goes to the source not served last
  always @(posedge out_clk_i) begin
    samp_take  = u_dual_clock_merge.samp_head_valid && u_dual_clock_merge.samp_head_ready;
    cmd_take   = u_dual_clock_merge.cmd_head_valid && u_dual_clock_merge.cmd_head_ready;
    both_heads = u_dual_clock_merge.samp_head_valid && u_dual_clock_merge.cmd_head_valid;
    if (rst_i) begin
      last_taken = SRC_SAMPLE;
    end else if (samp_take || cmd_take) begin
      if (rr_check_en && rr_seen_samp && rr_seen_cmd && both_heads) begin
        check_src("round-robin", (last_taken == SRC_SAMPLE) ? SRC_CMD : SRC_SAMPLE,
                  cmd_take ? SRC_CMD : SRC_SAMPLE);
      end
      last_taken = cmd_take ? SRC_CMD : SRC_SAMPLE;
      if (rr_check_en) begin
        rr_seen_samp = rr_seen_samp | samp_take;
        rr_seen_cmd  = rr_seen_cmd | cmd_take;
      end
    end
  end

  //////////////////////////////
  // Drivers
  //////////////////////////////

  task automatic wait_samp_accept();
    int cyc;
    cyc = 0;
    do begin
      @(posedge samp_clk_i);
      cyc++;
      if (cyc > TIMEOUT_CYCLES) abort_run("samp_ready_o stayed low past the timeout");
    end while (!samp_ready_o);
    exp_samp.push_back({{(WORD_W - SAMPLE_W){1'b0}}, samp_data_i});  // Upper byte zero
  endtask

  task automatic wait_cmd_accept();
    int cyc;
    cyc = 0;
    do begin
      @(posedge cmd_clk_i);
      cyc++;
      if (cyc > TIMEOUT_CYCLES) abort_run("cmd_ready_o stayed low past the timeout");
    end while (!cmd_ready_o);
    exp_cmd.push_back(cmd_data_i);  // Commands pass through unchanged
  endtask

  task automatic send_samples(input int n);
    @(posedge samp_clk_i);
    #1;
    for (int i = 0; i < n; i++) begin
      samp_valid_i = 1'b1;
      samp_data_i  = sample_t'(next_rand());
      wait_samp_accept();
      #1;
    end
    samp_valid_i = 1'b0;
  endtask

  task automatic send_cmds(input int n);
    @(posedge cmd_clk_i);
    #1;
    for (int i = 0; i < n; i++) begin
      cmd_valid_i = 1'b1;
      cmd_data_i  = cmd_t'(next_rand());
      wait_cmd_accept();
      #1;
    end
    cmd_valid_i = 1'b0;
  endtask

  // Keep one sample offered until acceptance stops, last one stays pending
  task automatic fill_until_stall(output int accepted);
    int idle;
    int cyc;
    accepted = 0;
    idle     = 0;
    cyc      = 0;
    @(posedge samp_clk_i);
    #1;
    samp_valid_i = 1'b1;
    samp_data_i  = sample_t'(next_rand());
    while (idle < STALL_CYCLES) begin
      @(posedge samp_clk_i);
      cyc++;
      if (cyc > TIMEOUT_CYCLES) abort_run("sample input never stopped accepting");
      if (samp_ready_o) begin
        exp_samp.push_back({{(WORD_W - SAMPLE_W){1'b0}}, samp_data_i});
        accepted++;
        idle = 0;
        #1;
        samp_data_i = sample_t'(next_rand());
      end else begin
        idle++;
      end
    end
  endtask

  // Roughly 3 of 4 cycles ready
  task automatic run_ready_pattern();
    logic [31:0] r;
    for (int cyc = 0; pattern_on && cyc < 16 * TIMEOUT_CYCLES; cyc++) begin
      @(posedge out_clk_i);
      #1;
      r           = next_rand();
      out_ready_i = r[0] | r[1];
    end
    out_ready_i = 1'b1;
  endtask

  task automatic wait_drain();
    int cyc;
    cyc = 0;
    while (exp_samp.size() != 0 || exp_cmd.size() != 0) begin
      @(posedge out_clk_i);
      #1;
      cyc++;
      if (cyc > TIMEOUT_CYCLES) abort_run("output did not deliver all expected words");
    end
  endtask

  //////////////////////////////
  // Tests
  //////////////////////////////

  task automatic test_reset_state();
    start_test("reset_state");
    @(posedge out_clk_i);
    #1;
    check_flag("out_valid_o", 1'b0, out_valid_o);
    check_flag("samp_ready_o", 1'b1, samp_ready_o);
    check_flag("cmd_ready_o", 1'b1, cmd_ready_o);
    finish_test();
  endtask

  task automatic test_one_stream(input stream_src_e src, input int n);
    int s0, c0;
    start_test(src == SRC_SAMPLE ? "sample_only" : "cmd_only");
    s0 = rx_samp;
    c0 = rx_cmd;
    if (src == SRC_SAMPLE) send_samples(n);
    else send_cmds(n);
    wait_drain();
    check_count("sample words", (src == SRC_SAMPLE) ? n : 0, rx_samp - s0);
    check_count("command words", (src == SRC_CMD) ? n : 0, rx_cmd - c0);
    finish_test();
  endtask

  task automatic test_both_streams();
    int s0, c0;
    start_test("both_streams");
    s0           = rx_samp;
    c0           = rx_cmd;
    rr_seen_samp = 1'b0;
    rr_seen_cmd  = 1'b0;
    rr_check_en  = 1'b1;
    fork
      send_samples(30);
      send_cmds(30);
    join
    wait_drain();
    rr_check_en = 1'b0;
    check_count("sample words", 30, rx_samp - s0);
    check_count("command words", 30, rx_cmd - c0);
    finish_test();
  endtask

  task automatic test_backpressure();
    int accepted;
    int s0;
    start_test("backpressure");
    s0 = rx_samp;
    @(posedge out_clk_i);
    #1;
    out_ready_i = 1'b0;
    fill_until_stall(accepted);
    check_count("accepted before stall", FIFO_DEPTH + 1, accepted);
    check_flag("out_valid_o held", 1'b1, out_valid_o);
    pattern_on = 1'b1;
    fork
      run_ready_pattern();
      begin
        wait_samp_accept();  // Pending word goes in once space frees
        #1;
        samp_valid_i = 1'b0;
        send_samples(6);
        wait_drain();
        pattern_on = 1'b0;
      end
    join
    check_count("sample words", FIFO_DEPTH + 8, rx_samp - s0);
    finish_test();
  endtask

  //////////////////////////////
  // Main sequence
  //////////////////////////////

  initial begin
    rst_i        = 1'b1;
    samp_valid_i = 1'b0;
    samp_data_i  = '0;
    cmd_valid_i  = 1'b0;
    cmd_data_i   = '0;
    out_ready_i  = 1'b1;
    rx_samp      = 0;
    rx_cmd       = 0;
    n_checks     = 0;
    n_errors     = 0;
    n_tests      = 0;
    repeat (4) @(posedge cmd_clk_i);  // Slowest clock covers all domains
    #1;
    rst_i = 1'b0;

    test_reset_state();
    test_one_stream(SRC_SAMPLE, 20);
    test_one_stream(SRC_CMD, 20);
    test_both_streams();
    test_backpressure();

    print_summary();
    if (n_errors == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule
